// ==== rtl/gemac_bridge_macros.svh ====
`ifndef GEMAC_BRIDGE_MACROS_SVH
`define GEMAC_BRIDGE_MACROS_SVH

// Client word, 16 data bits plus occ, eof, sof
`define GB_F19_W 19

// Short FIFO address width, 16 bytes deep
`define GB_SFIFO_AW 4

`endif

// ==== rtl/gemac_bridge_pkg.sv ====
package gemac_bridge_pkg;

   // Client word, data[15:8] goes out on the wire first
   typedef struct packed {
      logic        occ;
      logic        eof;
      logic        sof;
      logic [15:0] data;
   } f19_word_t;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_WAIT_ACK,
      TX_SEND,
      TX_DRAIN
   } txmac_state_e;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_FRAME,
      RX_FLUSH,
      RX_DROP
   } rxmac_state_e;

   // Byte slot within a client word
   typedef enum logic {
      UNPACK_HIGH,
      UNPACK_LOW
   } unpack_state_e;

endpackage

// ==== rtl/ll8_if.sv ====
interface ll8_if;

   logic [7:0] data;
   logic       sof;
   logic       eof;
   logic       src_rdy;
   logic       dst_rdy;

   modport src (
      output data,
      output sof,
      output eof,
      output src_rdy,
      input  dst_rdy
   );

   modport dst (
      input  data,
      input  sof,
      input  eof,
      input  src_rdy,
      output dst_rdy
   );

endinterface

// ==== rtl/fifo19_to_ll8.sv ====
module fifo19_to_ll8
   import gemac_bridge_pkg::*;
(
   input  logic      clk_i,
   input  logic      arst_n_i,
   input  f19_word_t f19_data_i,
   input  logic      f19_src_rdy_i,
   output logic      f19_dst_rdy_o,
   ll8_if.src        ll
);

   f19_word_t     word_r;
   logic          full_r;
   unpack_state_e slot_r;
   logic          last_byte;
   logic          ll_xfer;
   logic          f19_xfer;

   // A word with occ ends after its high byte
   assign last_byte = (slot_r == UNPACK_LOW) || word_r.occ;

   assign ll.data    = (slot_r == UNPACK_HIGH) ? word_r.data[15:8] : word_r.data[7:0];
   assign ll.sof     = (slot_r == UNPACK_HIGH) && word_r.sof;
   assign ll.eof     = last_byte && word_r.eof;
   assign ll.src_rdy = full_r;

   assign ll_xfer = ll.src_rdy && ll.dst_rdy;

   // Take the next word as the current one empties
   assign f19_dst_rdy_o = !full_r || (ll_xfer && last_byte);
   assign f19_xfer      = f19_src_rdy_i && f19_dst_rdy_o;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         full_r <= 1'b0;
         slot_r <= UNPACK_HIGH;
      end else begin
         if (f19_xfer) begin
            full_r <= 1'b1;
            slot_r <= UNPACK_HIGH;
         end else if (ll_xfer) begin
            if (last_byte) begin
               full_r <= 1'b0;
            end else begin
               slot_r <= UNPACK_LOW;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (f19_xfer) begin
         word_r <= f19_data_i;
      end
   end

endmodule

// ==== rtl/ll8_shortfifo.sv ====
`include "gemac_bridge_macros.svh"

module ll8_shortfifo #(
   parameter int AW = `GB_SFIFO_AW
) (
   input  logic clk_i,
   input  logic arst_n_i,
   ll8_if.dst   wr,
   ll8_if.src   rd
);

   localparam int DEPTH = 1 << AW;
   localparam logic [AW:0] FULL_CNT = DEPTH[AW:0];

   // Entry is {eof, sof, data}
   logic [9:0]    mem_r [DEPTH];
   logic [AW-1:0] wr_ptr_r;
   logic [AW-1:0] rd_ptr_r;
   logic [AW:0]   count_r;
   logic          wr_en;
   logic          rd_en;

   assign wr.dst_rdy = (count_r != FULL_CNT);
   assign rd.src_rdy = (count_r != '0);

   assign rd.data = mem_r[rd_ptr_r][7:0];
   assign rd.sof  = mem_r[rd_ptr_r][8];
   assign rd.eof  = mem_r[rd_ptr_r][9];

   assign wr_en = wr.src_rdy && wr.dst_rdy;
   assign rd_en = rd.src_rdy && rd.dst_rdy;

   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         mem_r[wr_ptr_r] <= {wr.eof, wr.sof, wr.data};
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr_r <= wr_ptr_r + 1'b1;
         end
         if (rd_en) begin
            rd_ptr_r <= rd_ptr_r + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count_r <= count_r + 1'b1;
            2'b01:   count_r <= count_r - 1'b1;
            default: count_r <= count_r;
         endcase
      end
   end

endmodule

// ==== rtl/ll8_to_txmac.sv ====
module ll8_to_txmac
   import gemac_bridge_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_n_i,
   ll8_if.dst         ll,
   output logic [7:0] tx_data_o,
   output logic       tx_valid_o,
   output logic       tx_error_o,
   input  logic       tx_ack_i
);

   txmac_state_e state_r;
   logic [7:0]   data_r;
   logic         valid_r;
   logic         error_r;
   logic         last_r;
   logic         advance;
   logic         xfer;

   // MAC takes the held byte this cycle
   assign advance = (state_r == TX_SEND) || ((state_r == TX_WAIT_ACK) && tx_ack_i);

   // Idle skips stray bytes until sof, drain discards to eof
   assign ll.dst_rdy = (state_r == TX_IDLE) || (state_r == TX_DRAIN) || (advance && !last_r);
   assign xfer       = ll.src_rdy && ll.dst_rdy;

   assign tx_data_o  = data_r;
   assign tx_valid_o = valid_r;
   assign tx_error_o = error_r;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_r <= TX_IDLE;
         valid_r <= 1'b0;
         error_r <= 1'b0;
         last_r  <= 1'b0;
      end else begin
         error_r <= 1'b0;
         case (state_r)
            TX_IDLE: begin
               if (xfer && ll.sof) begin
                  valid_r <= 1'b1;
                  last_r  <= ll.eof;
                  state_r <= TX_WAIT_ACK;
               end
            end
            TX_WAIT_ACK, TX_SEND: begin
               if (advance) begin
                  if (last_r) begin
                     valid_r <= 1'b0;
                     state_r <= TX_IDLE;
                  end else if (ll.src_rdy) begin
                     last_r  <= ll.eof;
                     state_r <= TX_SEND;
                  end else begin
                     // Underrun, flag it while valid is still up
                     error_r <= 1'b1;
                     state_r <= TX_DRAIN;
                  end
               end
            end
            TX_DRAIN: begin
               valid_r <= 1'b0;
               if (xfer && ll.eof) begin
                  state_r <= TX_IDLE;
               end
            end
            default: state_r <= TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (xfer && (state_r != TX_DRAIN)) begin
         data_r <= ll.data;
      end
   end

endmodule

// ==== rtl/rxmac_to_ll8.sv ====
module rxmac_to_ll8
   import gemac_bridge_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_n_i,
   input  logic [7:0] rx_data_i,
   input  logic       rx_valid_i,
   ll8_if.src         ll,
   output logic       rx_overrun_o
);

   rxmac_state_e state_r;
   logic [7:0]   hold_r;
   logic         first_r;
   logic         pend_r;
   logic         overrun_r;
   logic         xfer;
   logic         capture;

   // Held byte is known not to be last once the next one shows up
   assign ll.src_rdy = ((state_r == RX_FRAME) && rx_valid_i) || (state_r == RX_FLUSH) ||
                       ((state_r == RX_DROP) && pend_r);
   assign ll.eof     = (state_r == RX_FLUSH) || (state_r == RX_DROP);
   assign ll.sof     = first_r;
   assign ll.data    = hold_r;

   assign xfer = ll.src_rdy && ll.dst_rdy;

   assign capture = rx_valid_i &&
                    ((state_r == RX_IDLE) ||
                     (((state_r == RX_FRAME) || (state_r == RX_FLUSH)) && xfer));

   assign rx_overrun_o = overrun_r;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_r   <= RX_IDLE;
         first_r   <= 1'b0;
         pend_r    <= 1'b0;
         overrun_r <= 1'b0;
      end else begin
         overrun_r <= 1'b0;
         case (state_r)
            RX_IDLE: begin
               if (rx_valid_i) begin
                  first_r <= 1'b1;
                  state_r <= RX_FRAME;
               end
            end
            RX_FRAME: begin
               if (!rx_valid_i) begin
                  state_r <= RX_FLUSH;
               end else if (xfer) begin
                  first_r <= 1'b0;
               end else begin
                  overrun_r <= 1'b1;
                  pend_r    <= 1'b1;
                  state_r   <= RX_DROP;
               end
            end
            RX_FLUSH: begin
               if (xfer) begin
                  // Next frame may start right behind this one
                  if (rx_valid_i) begin
                     first_r <= 1'b1;
                     state_r <= RX_FRAME;
                  end else begin
                     state_r <= RX_IDLE;
                  end
               end else if (rx_valid_i) begin
                  overrun_r <= 1'b1;
                  pend_r    <= 1'b1;
                  state_r   <= RX_DROP;
               end
            end
            RX_DROP: begin
               if (xfer) begin
                  pend_r <= 1'b0;
               end
               if (!rx_valid_i && (xfer || !pend_r)) begin
                  state_r <= RX_IDLE;
               end
            end
            default: state_r <= RX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (capture) begin
         hold_r <= rx_data_i;
      end
   end

endmodule

// ==== rtl/ll8_to_fifo19.sv ====
module ll8_to_fifo19
   import gemac_bridge_pkg::*;
(
   input  logic      clk_i,
   input  logic      arst_n_i,
   ll8_if.dst        ll,
   output f19_word_t f19_data_o,
   output logic      f19_src_rdy_o,
   input  logic      f19_dst_rdy_i
);

   f19_word_t     word_r;
   logic          valid_r;
   unpack_state_e slot_r;
   logic [7:0]    hi_r;
   logic          hi_sof_r;
   logic          is_high;
   logic          xfer;

   // A sof byte always opens a new word
   assign is_high = (slot_r == UNPACK_HIGH) || ll.sof;

   // Hold off while a finished word is still waiting
   assign ll.dst_rdy = !valid_r || f19_dst_rdy_i;
   assign xfer       = ll.src_rdy && ll.dst_rdy;

   assign f19_data_o    = word_r;
   assign f19_src_rdy_o = valid_r;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid_r <= 1'b0;
         slot_r  <= UNPACK_HIGH;
      end else begin
         if (f19_dst_rdy_i) begin
            valid_r <= 1'b0;
         end
         if (xfer) begin
            if (is_high) begin
               if (ll.eof) begin
                  valid_r <= 1'b1;
                  slot_r  <= UNPACK_HIGH;
               end else begin
                  slot_r  <= UNPACK_LOW;
               end
            end else begin
               valid_r <= 1'b1;
               slot_r  <= UNPACK_HIGH;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (xfer) begin
         if (is_high) begin
            hi_r     <= ll.data;
            hi_sof_r <= ll.sof;
            if (ll.eof) begin
               word_r.occ  <= 1'b1;
               word_r.eof  <= 1'b1;
               word_r.sof  <= ll.sof;
               word_r.data <= {ll.data, 8'h00};
            end
         end else begin
            word_r.occ  <= 1'b0;
            word_r.eof  <= ll.eof;
            word_r.sof  <= hi_sof_r;
            word_r.data <= {hi_r, ll.data};
         end
      end
   end

endmodule

// ==== rtl/gemac_bridge.sv ====
`include "gemac_bridge_macros.svh"

module gemac_bridge
   import gemac_bridge_pkg::*;
(
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   // Client transmit words
   input  logic [`GB_F19_W-1:0] tx_f19_data_i,
   input  logic                 tx_f19_src_rdy_i,
   output logic                 tx_f19_dst_rdy_o,
   // Client receive words
   output logic [`GB_F19_W-1:0] rx_f19_data_o,
   output logic                 rx_f19_src_rdy_o,
   input  logic                 rx_f19_dst_rdy_i,
   // MAC transmitter
   output logic [7:0]           tx_data_o,
   output logic                 tx_valid_o,
   output logic                 tx_error_o,
   input  logic                 tx_ack_i,
   // MAC receiver
   input  logic [7:0]           rx_data_i,
   input  logic                 rx_valid_i,
   output logic                 rx_overrun_o
);

   f19_word_t tx_word;
   f19_word_t rx_word;

   // Typed view of the client vectors
   assign tx_word       = tx_f19_data_i;
   assign rx_f19_data_o = rx_word;

   ll8_if tx_ll ();
   ll8_if tx_ll2 ();
   ll8_if rx_ll ();
   ll8_if rx_ll2 ();

   // Transmit chain
   fifo19_to_ll8 tx_unpack (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .f19_data_i    (tx_word),
      .f19_src_rdy_i (tx_f19_src_rdy_i),
      .f19_dst_rdy_o (tx_f19_dst_rdy_o),
      .ll            (tx_ll)
   );

   ll8_shortfifo #(.AW(`GB_SFIFO_AW)) tx_sfifo (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .wr       (tx_ll),
      .rd       (tx_ll2)
   );

   ll8_to_txmac tx_adapt (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .ll         (tx_ll2),
      .tx_data_o  (tx_data_o),
      .tx_valid_o (tx_valid_o),
      .tx_error_o (tx_error_o),
      .tx_ack_i   (tx_ack_i)
   );

   // Receive chain
   rxmac_to_ll8 rx_adapt (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .rx_data_i    (rx_data_i),
      .rx_valid_i   (rx_valid_i),
      .ll           (rx_ll),
      .rx_overrun_o (rx_overrun_o)
   );

   ll8_shortfifo #(.AW(`GB_SFIFO_AW)) rx_sfifo (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .wr       (rx_ll),
      .rd       (rx_ll2)
   );

   ll8_to_fifo19 rx_pack (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .ll            (rx_ll2),
      .f19_data_o    (rx_word),
      .f19_src_rdy_o (rx_f19_src_rdy_o),
      .f19_dst_rdy_i (rx_f19_dst_rdy_i)
   );

endmodule

// ==== tests/tb_clk_gen.sv ====
module tb_clk_gen (
   output logic clk_o,
   output logic arst_n_o
);

   timeunit 1ns;
   timeprecision 100ps;

   localparam int HALF_PERIOD = 5;
   localparam int RST_CYCLES  = 8;

   initial begin
      clk_o = 1'b0;
      forever #(HALF_PERIOD) clk_o = ~clk_o;
   end

   initial begin
      arst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      #1;
      arst_n_o = 1'b1;
   end

endmodule

// ==== tests/gemac_bridge_assert.sv ====
`include "gemac_bridge_macros.svh"

module gemac_bridge_assert (
   input logic                 clk_i,
   input logic                 arst_n_i,
   input logic [7:0]           tx_data_o,
   input logic                 tx_valid_o,
   input logic                 tx_error_o,
   input logic                 tx_ack_i,
   input logic                 rx_overrun_o,
   input logic [`GB_F19_W-1:0] rx_f19_data_o,
   input logic                 rx_f19_src_rdy_o,
   input logic                 rx_f19_dst_rdy_i
);

   timeunit 1ns;
   timeprecision 100ps;

   // Set once the MAC has acked the first byte of a frame
   logic acked_r;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         acked_r <= 1'b0;
      end else if (!tx_valid_o) begin
         acked_r <= 1'b0;
      end else if (tx_ack_i) begin
         acked_r <= 1'b1;
      end
   end

   tx_error_with_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      tx_error_o |-> tx_valid_o)
      else $error("tx_error_o high without tx_valid_o");

   tx_first_byte_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (tx_valid_o && $past(tx_valid_o) && !acked_r) |-> $stable(tx_data_o))
      else $error("tx_data_o changed before the MAC acked");

   rx_overrun_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rx_overrun_o |=> !rx_overrun_o)
      else $error("rx_overrun_o high for two cycles");

   rx_word_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (rx_f19_src_rdy_o && !rx_f19_dst_rdy_i) |=> $stable(rx_f19_data_o))
      else $error("rx_f19_data_o changed while stalled");

endmodule

// ==== tests/tb_gemac_bridge.sv ====
module tb_gemac_bridge
   import gemac_bridge_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int WAIT_LIMIT = 2000;
   localparam int NUM_TESTS  = 6;
   localparam int TIMEOUT_NS = NUM_TESTS * WAIT_LIMIT * 10;

   logic       clk;
   logic       arst_n;
   f19_word_t  tx_f19_data;
   logic       tx_f19_src_rdy;
   logic       tx_f19_dst_rdy;
   f19_word_t  rx_f19_data;
   logic       rx_f19_src_rdy;
   logic       rx_f19_dst_rdy;
   logic [7:0] tx_data;
   logic       tx_valid;
   logic       tx_error;
   logic       tx_ack;
   logic [7:0] rx_data;
   logic       rx_valid;
   logic       rx_overrun;

   // Expected frame bytes and what the MAC and client models saw
   logic [7:0] frame_q [$];
   logic [7:0] tx_cur [$];
   logic [7:0] tx_last [$];
   f19_word_t  rx_words [$];
   int         tx_frames = 0;
   int         tx_err_cnt = 0;
   int         rx_eofs = 0;
   int         rx_overruns = 0;
   int         rx_mode;
   int         checks;
   int         errors;
   int         tests_run;
   int         tests_failed;

   tb_clk_gen clk_gen0 (
      .clk_o    (clk),
      .arst_n_o (arst_n)
   );

   gemac_bridge dut0 (
      .clk_i            (clk),
      .arst_n_i         (arst_n),
      .tx_f19_data_i    (tx_f19_data),
      .tx_f19_src_rdy_i (tx_f19_src_rdy),
      .tx_f19_dst_rdy_o (tx_f19_dst_rdy),
      .rx_f19_data_o    (rx_f19_data),
      .rx_f19_src_rdy_o (rx_f19_src_rdy),
      .rx_f19_dst_rdy_i (rx_f19_dst_rdy),
      .tx_data_o        (tx_data),
      .tx_valid_o       (tx_valid),
      .tx_error_o       (tx_error),
      .tx_ack_i         (tx_ack),
      .rx_data_i        (rx_data),
      .rx_valid_i       (rx_valid),
      .rx_overrun_o     (rx_overrun)
   );

   bind gemac_bridge gemac_bridge_assert bridge_assert0 (
      .clk_i            (clk_i),
      .arst_n_i         (arst_n_i),
      .tx_data_o        (tx_data_o),
      .tx_valid_o       (tx_valid_o),
      .tx_error_o       (tx_error_o),
      .tx_ack_i         (tx_ack_i),
      .rx_overrun_o     (rx_overrun_o),
      .rx_f19_data_o    (rx_f19_data_o),
      .rx_f19_src_rdy_o (rx_f19_src_rdy_o),
      .rx_f19_dst_rdy_i (rx_f19_dst_rdy_i)
   );

   // MAC transmitter acks the first byte after 1 to 4 cycles
   initial begin : mac_tx_model
      int   delay;
      logic acked;
      tx_ack = 1'b0;
      acked  = 1'b0;
      wait (arst_n === 1'b1);
      forever begin
         @(posedge clk);
         if (tx_valid && !acked) begin
            delay = $urandom_range(4, 1);
            repeat (delay - 1) @(posedge clk);
            #1;
            tx_ack = 1'b1;
            @(posedge clk);
            tx_cur.push_back(tx_data);
            acked = 1'b1;
            #1;
            tx_ack = 1'b0;
         end else if (tx_valid) begin
            if (tx_error) begin
               tx_err_cnt++;
            end else begin
               tx_cur.push_back(tx_data);
            end
         end else if (acked) begin
            tx_last = tx_cur;
            tx_cur.delete();
            tx_frames++;
            acked = 1'b0;
         end
      end
   end

   // Client receive ready per rx_mode (0 ready, 1 random, 2 stalled)
   initial begin : rx_client_ready
      int mode;
      rx_f19_dst_rdy = 1'b1;
      forever begin
         @(posedge clk);
         mode = rx_mode;
         #1;
         case (mode)
            0:       rx_f19_dst_rdy = 1'b1;
            1:       rx_f19_dst_rdy = ($urandom_range(1, 0) == 1);
            default: rx_f19_dst_rdy = 1'b0;
         endcase
      end
   end

   always @(posedge clk) begin
      if (arst_n) begin
         if (rx_f19_src_rdy && rx_f19_dst_rdy) begin
            rx_words.push_back(rx_f19_data);
            if (rx_f19_data.eof) begin
               rx_eofs++;
            end
         end
         if (rx_overrun) begin
            rx_overruns++;
         end
      end
   end

   initial begin : watchdog
      #(TIMEOUT_NS);
      $display("Run timed out after %0d ns", TIMEOUT_NS);
      $display("Checks failed");
      $finish;
   end

   task automatic check_word(input f19_word_t got, input f19_word_t exp, input string what);
      logic bad;
      checks++;
      bad = (got.sof !== exp.sof) || (got.eof !== exp.eof) || (got.occ !== exp.occ) ||
            (got.data[15:8] !== exp.data[15:8]) ||
            (!exp.occ && (got.data[7:0] !== exp.data[7:0]));
      if (bad) begin
         $display("Fail at %0d ns: %s got %05h expected %05h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         $display("Fail at %0d ns: %s got %02h expected %02h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      checks++;
      if (got != exp) begin
         $display("Fail at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic fill_frame(input int len);
      int i;
      frame_q.delete();
      for (i = 0; i < len; i++) begin
         frame_q.push_back(8'($urandom));
      end
   endtask

   // Client word idx of the expected frame with the high byte first on the wire
   function automatic f19_word_t word_from_frame(input int idx);
      f19_word_t w;
      int        nwords;
      nwords       = (frame_q.size() + 1) / 2;
      w.sof        = (idx == 0);
      w.eof        = (idx == nwords - 1);
      w.occ        = w.eof && ((frame_q.size() % 2) == 1);
      w.data[15:8] = frame_q[2 * idx];
      if (w.occ) begin
         w.data[7:0] = 8'h00;
      end else begin
         w.data[7:0] = frame_q[2 * idx + 1];
      end
      return w;
   endfunction

   task automatic send_tx_frame(input int stall_word, input int stall_cycles);
      int i;
      int nwords;
      nwords = (frame_q.size() + 1) / 2;
      @(posedge clk);
      #1;
      for (i = 0; i < nwords; i++) begin
         if (i == stall_word) begin
            tx_f19_src_rdy = 1'b0;
            repeat (stall_cycles) @(posedge clk);
            #1;
         end
         tx_f19_data    = word_from_frame(i);
         tx_f19_src_rdy = 1'b1;
         @(posedge clk);
         while (!tx_f19_dst_rdy) @(posedge clk);
         #1;
      end
      tx_f19_src_rdy = 1'b0;
   endtask

   task automatic feed_rx_frame();
      int i;
      @(posedge clk);
      #1;
      for (i = 0; i < frame_q.size(); i++) begin
         rx_valid = 1'b1;
         rx_data  = frame_q[i];
         @(posedge clk);
         #1;
      end
      rx_valid = 1'b0;
      rx_data  = 8'h00;
   endtask

   task automatic wait_tx_frames(input int target);
      int n;
      n = 0;
      while ((tx_frames < target) && (n < WAIT_LIMIT)) begin
         @(posedge clk);
         n++;
      end
      if (tx_frames < target) begin
         $display("Timed out at %0d ns waiting for the MAC to finish a frame", $time);
         errors++;
      end
      #1;
   endtask

   task automatic wait_rx_eofs(input int target);
      int n;
      n = 0;
      while ((rx_eofs < target) && (n < WAIT_LIMIT)) begin
         @(posedge clk);
         n++;
      end
      if (rx_eofs < target) begin
         $display("Timed out at %0d ns waiting for a received frame to end", $time);
         errors++;
      end
      #1;
   endtask

   task automatic compare_tx_frame();
      int i;
      check_count(tx_last.size(), frame_q.size(), "transmit byte count");
      for (i = 0; (i < tx_last.size()) && (i < frame_q.size()); i++) begin
         check_byte(tx_last[i], frame_q[i], "transmit byte");
      end
   endtask

   task automatic compare_rx_frame(input int first);
      int i;
      int nwords;
      nwords = (frame_q.size() + 1) / 2;
      check_count(rx_words.size() - first, nwords, "receive word count");
      for (i = 0; (i < nwords) && (first + i < rx_words.size()); i++) begin
         check_word(rx_words[first + i], word_from_frame(i), "receive word");
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      tests_run++;
      if (errors == err_before) begin
         $display("Test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: %0d errors", tests_run, name, errors - err_before);
      end
   endtask

   task automatic tx_plain_frame(input int len, input string name);
      int e0;
      int f0;
      int err0;
      e0   = errors;
      f0   = tx_frames;
      err0 = tx_err_cnt;
      fill_frame(len);
      send_tx_frame(-1, 0);
      wait_tx_frames(f0 + 1);
      compare_tx_frame();
      check_count(tx_err_cnt - err0, 0, "transmit error pulses");
      report_test(name, e0);
   endtask

   task automatic tx_underrun();
      int e0;
      int f0;
      int err0;
      int i;
      e0   = errors;
      f0   = tx_frames;
      err0 = tx_err_cnt;
      fill_frame(30);
      send_tx_frame(6, 40);
      wait_tx_frames(f0 + 1);
      check_count(tx_err_cnt - err0, 1, "underrun error pulses");
      check_count(int'((tx_last.size() > 0) && (tx_last.size() < frame_q.size())), 1,
                  "underrun frame cut short");
      for (i = 0; (i < tx_last.size()) && (i < frame_q.size()); i++) begin
         check_byte(tx_last[i], frame_q[i], "underrun prefix byte");
      end
      // Frame behind the cut one
      f0   = tx_frames;
      err0 = tx_err_cnt;
      fill_frame(10);
      send_tx_frame(-1, 0);
      wait_tx_frames(f0 + 1);
      compare_tx_frame();
      check_count(tx_err_cnt - err0, 0, "error pulses after underrun");
      report_test("transmit underrun", e0);
   endtask

   task automatic rx_odd_frame();
      int e0;
      int first;
      int eofs0;
      int ovr0;
      e0    = errors;
      first = rx_words.size();
      eofs0 = rx_eofs;
      ovr0  = rx_overruns;
      fill_frame(7);
      feed_rx_frame();
      wait_rx_eofs(eofs0 + 1);
      compare_rx_frame(first);
      check_count(rx_overruns - ovr0, 0, "receive overrun pulses");
      report_test("odd receive frame", e0);
   endtask

   task automatic rx_backpressure();
      int e0;
      int ovr0;
      int n;
      int first;
      int eofs0;
      e0      = errors;
      ovr0    = rx_overruns;
      rx_mode = 1;
      for (n = 0; n < 4; n++) begin
         first = rx_words.size();
         eofs0 = rx_eofs;
         fill_frame($urandom_range(12, 3));
         feed_rx_frame();
         wait_rx_eofs(eofs0 + 1);
         compare_rx_frame(first);
      end
      rx_mode = 0;
      check_count(rx_overruns - ovr0, 0, "overrun pulses under back-pressure");
      report_test("receive back-pressure", e0);
   endtask

   task automatic rx_overrun_frame();
      int         e0;
      int         ovr0;
      int         first;
      int         eofs0;
      int         i;
      f19_word_t  w;
      logic [7:0] got_q [$];
      e0      = errors;
      ovr0    = rx_overruns;
      first   = rx_words.size();
      eofs0   = rx_eofs;
      rx_mode = 2;
      fill_frame(64);
      feed_rx_frame();
      repeat (4) @(posedge clk);
      #1;
      rx_mode = 0;
      wait_rx_eofs(eofs0 + 1);
      check_count(rx_overruns - ovr0, 1, "overrun pulses");
      check_count(int'(rx_words.size() > first), 1, "overrun frame delivered");
      if (rx_words.size() > first) begin
         check_count(int'(rx_words[first].sof), 1, "sof on first overrun word");
         check_count(int'(rx_words[rx_words.size() - 1].eof), 1, "eof on last overrun word");
      end
      for (i = first; i < rx_words.size(); i++) begin
         w = rx_words[i];
         got_q.push_back(w.data[15:8]);
         if (!w.occ) begin
            got_q.push_back(w.data[7:0]);
         end
      end
      check_count(int'(got_q.size() <= frame_q.size()), 1, "overrun prefix length");
      for (i = 0; (i < got_q.size()) && (i < frame_q.size()); i++) begin
         check_byte(got_q[i], frame_q[i], "overrun prefix byte");
      end
      // Next frame must come through whole
      first = rx_words.size();
      eofs0 = rx_eofs;
      fill_frame(9);
      feed_rx_frame();
      wait_rx_eofs(eofs0 + 1);
      compare_rx_frame(first);
      report_test("receive overrun", e0);
   endtask

   initial begin : main_seq
      checks         = 0;
      errors         = 0;
      tests_run      = 0;
      tests_failed   = 0;
      rx_mode        = 0;
      tx_f19_data    = '0;
      tx_f19_src_rdy = 1'b0;
      rx_data        = 8'h00;
      rx_valid       = 1'b0;
      void'($urandom(10));
      wait (arst_n === 1'b1);
      repeat (2) @(posedge clk);
      tx_plain_frame(12, "even transmit frame");
      tx_plain_frame(7, "odd transmit frame");
      tx_underrun();
      rx_odd_frame();
      rx_backpressure();
      rx_overrun_frame();
      $display("Tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// ==== gemac_bridge.f ====
+incdir+rtl
rtl/gemac_bridge_pkg.sv
rtl/ll8_if.sv
rtl/fifo19_to_ll8.sv
rtl/ll8_shortfifo.sv
rtl/ll8_to_txmac.sv
rtl/rxmac_to_ll8.sv
rtl/ll8_to_fifo19.sv
rtl/gemac_bridge.sv
tests/tb_clk_gen.sv
tests/gemac_bridge_assert.sv
tests/tb_gemac_bridge.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_gemac_bridge
FILELIST  ?= gemac_bridge.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard rtl/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
